/* ahb_bus_pkg.sv */
// AHB-Lite transfer encodings shared by the bus adapter, the top and the testbench
`default_nettype none

package ahb_bus_pkg;

   // HTRANS encodings
   typedef enum logic [1:0] {
      HTRANS_IDLE   = 2'b00,
      HTRANS_BUSY   = 2'b01,
      HTRANS_NONSEQ = 2'b10,
      HTRANS_SEQ    = 2'b11
   } htrans_e;

   // HSIZE encodings, only up to a dword on a 64-bit bus
   typedef enum logic [2:0] {
      HSIZE_BYTE  = 3'b000,
      HSIZE_HALF  = 3'b001,
      HSIZE_WORD  = 3'b010,
      HSIZE_DWORD = 3'b011
   } hsize_e;

endpackage

`default_nettype wire

/* ahb_cfg.svh */
// bus widths and register block sizing for the AHB register peripheral
// include in any file that needs these sizes before use
`ifndef AHB_CFG_SVH
`define AHB_CFG_SVH

// AHB-Lite data bus
`define AHB_DATA_WIDTH 64

// client port data, 32 or 64
`define CLIENT_DATA_WIDTH 32

`define ADDR_WIDTH 32

// register block contents
`define REG_FIFO_DEPTH 4
`define REG_NUM_SCRATCH 8

// value returned by the ID register
`define REG_BLK_ID 32'h5c2a_0101

`endif

/* ahb_reg_top.sv */
// top level of the AHB register peripheral with plain AHB-Lite ports
// joins the bus adapter and the register block through the client bundle
`timescale 1ns/1ps
`default_nettype none
`include "ahb_cfg.svh"

module ahb_reg_top (
   input  wire logic                         hclk,
   input  wire logic                         hreset_n,

   input  wire logic [`ADDR_WIDTH-1:0]       haddr_i,
   input  wire logic [`AHB_DATA_WIDTH-1:0]   hwdata_i,
   input  wire logic                         hsel_i,
   input  wire logic                         hwrite_i,
   input  wire logic                         hready_i,
   input  wire ahb_bus_pkg::htrans_e         htrans_i,
   input  wire ahb_bus_pkg::hsize_e          hsize_i,

   output logic                              hresp_o,
   output logic                              hreadyout_o,
   output logic [`AHB_DATA_WIDTH-1:0]        hrdata_o
);

   // adapter to client strobes
   client_if #(
      .ADDR_WIDTH (`ADDR_WIDTH),
      .DATA_WIDTH (`CLIENT_DATA_WIDTH)
   ) cif ();

   ahb_slv_sif #(
      .AHB_DATA_WIDTH    (`AHB_DATA_WIDTH),
      .CLIENT_DATA_WIDTH (`CLIENT_DATA_WIDTH),
      .ADDR_WIDTH        (`ADDR_WIDTH)
   ) u_ahb_slv_sif (
      .hclk        (hclk),
      .hreset_n    (hreset_n),
      .haddr_i     (haddr_i),
      .hwdata_i    (hwdata_i),
      .hsel_i      (hsel_i),
      .hwrite_i    (hwrite_i),
      .hready_i    (hready_i),
      .htrans_i    (htrans_i),
      .hsize_i     (hsize_i),
      .hresp_o     (hresp_o),
      .hreadyout_o (hreadyout_o),
      .hrdata_o    (hrdata_o),
      .cif         (cif.sif)
   );

   scratch_reg_blk #(
      .FIFO_DEPTH (`REG_FIFO_DEPTH)
   ) u_scratch_reg_blk (
      .hclk     (hclk),
      .hreset_n (hreset_n),
      .cif      (cif.client)
   );

endmodule

`default_nettype wire

/* ahb_slv_sif.sv */
// AHB-Lite slave adapter, turns address and data phases into client strobes
// supports a 64-bit bus with a 32-bit or a 64-bit client
`timescale 1ns/1ps
`default_nettype none
`include "ahb_cfg.svh"

module ahb_slv_sif #(
   parameter int AHB_DATA_WIDTH    = `AHB_DATA_WIDTH,
   parameter int CLIENT_DATA_WIDTH = `CLIENT_DATA_WIDTH,
   parameter int ADDR_WIDTH        = `ADDR_WIDTH
) (
   input  wire logic                      hclk,
   input  wire logic                      hreset_n,

   // AHB-Lite slave side
   input  wire logic [ADDR_WIDTH-1:0]     haddr_i,
   input  wire logic [AHB_DATA_WIDTH-1:0] hwdata_i,
   input  wire logic                      hsel_i,
   input  wire logic                      hwrite_i,
   input  wire logic                      hready_i,
   input  wire ahb_bus_pkg::htrans_e      htrans_i,
   input  wire ahb_bus_pkg::hsize_e       hsize_i,
   output logic                           hresp_o,
   output logic                           hreadyout_o,
   output logic [AHB_DATA_WIDTH-1:0]      hrdata_o,

   // client side
   client_if.sif                          cif
);

   import ahb_bus_pkg::*;

   localparam int CW = CLIENT_DATA_WIDTH;

   logic   xfer_valid;
   hsize_e size_q;

   // only nonseq and seq carry a real transfer
   assign xfer_valid = hsel_i && (htrans_i == HTRANS_NONSEQ || htrans_i == HTRANS_SEQ);

   // address phase capture, held while the bus is stalled
   always_ff @(posedge hclk or negedge hreset_n) begin
      if (!hreset_n) begin
         cif.dv    <= 1'b0;
         cif.write <= 1'b0;
         cif.addr  <= '0;
         size_q    <= HSIZE_BYTE;
      end else begin
         if (hready_i) begin
            cif.dv <= xfer_valid;
         end
         if (hready_i && hsel_i) begin
            cif.addr  <= haddr_i;
            cif.write <= hwrite_i && xfer_valid;
            size_q    <= hsize_i;
         end
      end
   end

   generate
      if (CW == AHB_DATA_WIDTH) begin : g_full_lane
         // client as wide as the bus
         always_comb begin
            case (size_q)
               HSIZE_BYTE: cif.wdata = {{(CW-8){1'b0}}, hwdata_i[7:0]};
               HSIZE_HALF: cif.wdata = {{(CW-16){1'b0}}, hwdata_i[15:0]};
               HSIZE_WORD: begin
                  cif.wdata = cif.addr[2] ? {{(CW-32){1'b0}}, hwdata_i[63:32]}
                                          : {{(CW-32){1'b0}}, hwdata_i[31:0]};
               end
               default: cif.wdata = hwdata_i;
            endcase
         end

         assign hrdata_o = cif.rdata;
      end else begin : g_half_lane
         // half width client, lane picked by addr bit 2
         always_comb begin
            case (size_q)
               HSIZE_BYTE: cif.wdata = {{(CW-8){1'b0}}, hwdata_i[7:0]};
               HSIZE_HALF: cif.wdata = {{(CW-16){1'b0}}, hwdata_i[15:0]};
               default:    cif.wdata = cif.addr[2] ? hwdata_i[2*CW-1:CW] : hwdata_i[CW-1:0];
            endcase
         end

         assign hrdata_o = cif.addr[2] ? {cif.rdata, {CW{1'b0}}} : {{CW{1'b0}}, cif.rdata};
      end
   endgenerate

   // client levels map straight onto the AHB response
   assign hreadyout_o = ~cif.hold;
   assign hresp_o     = cif.error;

   // an idle or busy address phase never opens a data phase
   a_no_dv_from_idle: assert property (
      @(posedge hclk) disable iff (!hreset_n)
      (hready_i && (htrans_i == HTRANS_IDLE || htrans_i == HTRANS_BUSY)) |=> !cif.dv
   );

endmodule

`default_nettype wire

/* client_if.sv */
// strobe bundle between the AHB slave adapter and its register client
// the adapter takes the sif modport, the register block the client modport
`timescale 1ns/1ps
`default_nettype none
`include "ahb_cfg.svh"

interface client_if #(
   parameter int ADDR_WIDTH = `ADDR_WIDTH,
   parameter int DATA_WIDTH = `CLIENT_DATA_WIDTH
);

   // data phase valid and its attributes
   logic                  dv;
   logic                  write;
   logic [ADDR_WIDTH-1:0] addr;
   logic [DATA_WIDTH-1:0] wdata;

   // client response levels
   logic                  hold;
   logic                  error;
   logic [DATA_WIDTH-1:0] rdata;

   modport sif (output dv, write, addr, wdata, input hold, error, rdata);

   modport client (input dv, write, addr, wdata, output hold, error, rdata);

endinterface

`default_nettype wire

/* list.f */
+incdir+.
ahb_bus_pkg.sv
reg_blk_pkg.sv
client_if.sv
ahb_slv_sif.sv
scratch_reg_blk.sv
ahb_reg_top.sv
tb_ahb_reg_top.sv

/* reg_blk_pkg.sv */
// register map and response states of the scratch register block
// word offsets are taken from address bits 7 to 2
`default_nettype none

package reg_blk_pkg;

   // address bits that select a register
   localparam int REG_OFF_MSB = 7;
   localparam int REG_OFF_LSB = 2;

   // word offsets, byte address is offset times four
   typedef enum logic [REG_OFF_MSB-REG_OFF_LSB:0] {
      REG_ID        = 6'h00,
      REG_CTRL      = 6'h01,
      REG_FIFO_DATA = 6'h02,
      REG_FIFO_STAT = 6'h03,
      REG_SCRATCH0  = 6'h10,
      REG_SCRATCH1  = 6'h11,
      REG_SCRATCH2  = 6'h12,
      REG_SCRATCH3  = 6'h13,
      REG_SCRATCH4  = 6'h14,
      REG_SCRATCH5  = 6'h15,
      REG_SCRATCH6  = 6'h16,
      REG_SCRATCH7  = 6'h17
   } reg_addr_e;

   // CTRL fields
   localparam int CTRL_LOCK_BIT = 0;

   // FIFO_STAT fields, count sits in the low bits
   localparam int STAT_EMPTY_BIT = 8;
   localparam int STAT_FULL_BIT  = 9;

   // client response FSM
   typedef enum logic [1:0] {
      RESP_READY = 2'b00,
      RESP_WAIT  = 2'b01,
      RESP_ERR2  = 2'b10
   } resp_state_e;

endpackage

`default_nettype wire

/* scratch_reg_blk.sv */
// register client with ID, lock control, scratch words and a small word FIFO
// adds one wait state to FIFO reads and a two-cycle error on illegal accesses
`timescale 1ns/1ps
`default_nettype none
`include "ahb_cfg.svh"

module scratch_reg_blk #(
   parameter int FIFO_DEPTH = `REG_FIFO_DEPTH
) (
   input  wire logic hclk,
   input  wire logic hreset_n,
   client_if.client  cif
);

   import reg_blk_pkg::*;

   localparam int DW          = `CLIENT_DATA_WIDTH;
   localparam int NUM_SCRATCH = `REG_NUM_SCRATCH;
   localparam int SCR_IDX_W   = $clog2(NUM_SCRATCH);
   localparam int PTR_W       = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W       = $clog2(FIFO_DEPTH + 1);
   localparam int OFF_W       = REG_OFF_MSB - REG_OFF_LSB + 1;

   resp_state_e          state_q;
   resp_state_e          state_d;
   reg_addr_e            reg_sel;
   logic [OFF_W-1:0]     word_off;
   logic [OFF_W-1:0]     scr_off;
   logic [SCR_IDX_W-1:0] scr_idx;
   logic                 is_scratch;

   logic                 lock_q;
   logic [DW-1:0]        scratch_q [NUM_SCRATCH];

   logic [DW-1:0]        fifo_mem [FIFO_DEPTH];
   logic [PTR_W-1:0]     wr_ptr_q;
   logic [PTR_W-1:0]     rd_ptr_q;
   logic [CNT_W-1:0]     fifo_cnt_q;
   logic                 fifo_empty;
   logic                 fifo_full;
   logic [DW-1:0]        fifo_rdata_q;
   logic [DW-1:0]        stat_word;

   logic                 illegal;
   logic                 accept;
   logic                 fifo_rd_start;
   logic                 ctrl_we;
   logic                 scratch_we;
   logic                 fifo_push;
   logic                 fifo_pop;

   // address decode
   assign word_off   = cif.addr[REG_OFF_MSB:REG_OFF_LSB];
   assign reg_sel    = reg_addr_e'(word_off);
   assign scr_off    = word_off - REG_SCRATCH0;
   assign scr_idx    = scr_off[SCR_IDX_W-1:0];
   assign is_scratch = (word_off >= REG_SCRATCH0) && (scr_off < NUM_SCRATCH);

   assign fifo_empty = (fifo_cnt_q == '0);
   assign fifo_full  = (fifo_cnt_q == CNT_W'(FIFO_DEPTH));

   // all illegal access rules in one place
   always_comb begin
      case (reg_sel)
         REG_ID, REG_FIFO_STAT: illegal = cif.write;
         REG_CTRL:              illegal = 1'b0;
         REG_FIFO_DATA:         illegal = cif.write ? fifo_full : fifo_empty;
         default:               illegal = !is_scratch || (cif.write && lock_q);
      endcase
   end

   // response FSM driving hold and error
   always_comb begin
      state_d       = state_q;
      cif.hold      = 1'b0;
      cif.error     = 1'b0;
      accept        = 1'b0;
      fifo_rd_start = 1'b0;
      case (state_q)
         RESP_READY: begin
            if (cif.dv) begin
               if (illegal) begin
                  // first error cycle stalls the bus
                  cif.hold  = 1'b1;
                  cif.error = 1'b1;
                  state_d   = RESP_ERR2;
               end else if (!cif.write && reg_sel == REG_FIFO_DATA) begin
                  cif.hold      = 1'b1;
                  fifo_rd_start = 1'b1;
                  state_d       = RESP_WAIT;
               end else begin
                  accept = 1'b1;
               end
            end
         end
         // FIFO read completes here
         RESP_WAIT: state_d = RESP_READY;
         RESP_ERR2: begin
            cif.error = 1'b1;
            state_d   = RESP_READY;
         end
         default: state_d = RESP_READY;
      endcase
   end

   assign ctrl_we    = accept && cif.write && (reg_sel == REG_CTRL);
   assign scratch_we = accept && cif.write && is_scratch;
   assign fifo_push  = accept && cif.write && (reg_sel == REG_FIFO_DATA);
   assign fifo_pop   = (state_q == RESP_WAIT);

   always_ff @(posedge hclk or negedge hreset_n) begin
      if (!hreset_n) begin
         state_q    <= RESP_READY;
         lock_q     <= 1'b0;
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         fifo_cnt_q <= '0;
      end else begin
         state_q <= state_d;
         if (ctrl_we) begin
            lock_q <= cif.wdata[CTRL_LOCK_BIT];
         end
         if (fifo_push) begin
            wr_ptr_q   <= (wr_ptr_q == PTR_W'(FIFO_DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
            fifo_cnt_q <= fifo_cnt_q + 1'b1;
         end
         if (fifo_pop) begin
            rd_ptr_q   <= (rd_ptr_q == PTR_W'(FIFO_DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
            fifo_cnt_q <= fifo_cnt_q - 1'b1;
         end
      end
   end

   // scratch and FIFO storage
   always_ff @(posedge hclk) begin
      if (scratch_we) begin
         scratch_q[scr_idx] <= cif.wdata;
      end
      if (fifo_push) begin
         fifo_mem[wr_ptr_q] <= cif.wdata;
      end
      // head word captured during the wait cycle
      if (fifo_rd_start) begin
         fifo_rdata_q <= fifo_mem[rd_ptr_q];
      end
   end

   always_comb begin
      stat_word                 = '0;
      stat_word[CNT_W-1:0]      = fifo_cnt_q;
      stat_word[STAT_EMPTY_BIT] = fifo_empty;
      stat_word[STAT_FULL_BIT]  = fifo_full;
   end

   // read mux
   always_comb begin
      cif.rdata = '0;
      if (state_q == RESP_WAIT) begin
         cif.rdata = fifo_rdata_q;
      end else begin
         case (reg_sel)
            REG_ID:        cif.rdata = `REG_BLK_ID;
            REG_CTRL:      cif.rdata[CTRL_LOCK_BIT] = lock_q;
            REG_FIFO_STAT: cif.rdata = stat_word;
            default: begin
               if (is_scratch) begin
                  cif.rdata = scratch_q[scr_idx];
               end
            end
         endcase
      end
   end

   // error always spans a stalled cycle then a ready cycle
   a_error_two_cycles: assert property (
      @(posedge hclk) disable iff (!hreset_n)
      $rose(cif.error) |-> cif.hold ##1 (cif.error && !cif.hold)
   );

   a_fifo_cnt_bound: assert property (
      @(posedge hclk) disable iff (!hreset_n)
      fifo_cnt_q <= CNT_W'(FIFO_DEPTH)
   );

endmodule

`default_nettype wire

/* tb_ahb_reg_tasks.svh */
// AHB-Lite driver, compare and directed test tasks for the register peripheral testbench
// included inside the testbench module body and uses its bus signals and reference model
`ifndef TB_AHB_REG_TASKS_SVH
`define TB_AHB_REG_TASKS_SVH

function automatic logic [31:0] reg_addr(input reg_addr_e r);
   return BASE_ADDR + (32'(r) << 2);
endfunction

function automatic reg_addr_e scratch_sel(input int i);
   return reg_addr_e'(int'(REG_SCRATCH0) + i);
endfunction

// FIFO_STAT holds the count in bits 2..0, empty in bit 8 and full in bit 9
function automatic logic [31:0] stat_expect(input int cnt);
   logic [31:0] word;
   word    = 32'(cnt) & 32'h7;
   word[8] = (cnt == 0);
   word[9] = (cnt == `REG_FIFO_DEPTH);
   return word;
endfunction

task automatic check_data(input logic [`CLIENT_DATA_WIDTH-1:0] exp, got, input string msg);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("Fail %0t: %s expected %h got %h", $time, msg, exp, got);
   end
endtask

task automatic check_resp(input logic exp, got, input string msg);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("Fail %0t: %s expected hresp %b got %b", $time, msg, exp, got);
   end
endtask

task automatic check_waits(input int exp, got, input string msg);
   checks++;
   if (got != exp) begin
      errors++;
      $display("Fail %0t: %s expected %0d wait states got %0d", $time, msg, exp, got);
   end
endtask

task automatic check_addr_state(input reg_addr_e r, input logic [31:0] exp, got);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("Fail %0t: register %s expected %h got %h", $time, r.name(), exp, got);
   end
endtask

// bus must be ready with an OKAY response
task automatic check_bus_quiet(input string msg);
   checks++;
   if (hreadyout_o !== 1'b1 || hresp_o !== 1'b0) begin
      errors++;
      $display("Fail %0t: %s expected hreadyout 1 hresp 0 got hreadyout %b hresp %b",
               $time, msg, hreadyout_o, hresp_o);
   end
endtask

task automatic drive_idle();
   htrans_i <= HTRANS_IDLE;
   hsel_i   <= 1'b0;
   hwrite_i <= 1'b0;
endtask

// one transfer with its address phase and a data phase that lasts until hreadyout
task automatic ahb_xfer(input logic [31:0] addr, input logic wr, input hsize_e size,
                        input logic [63:0] wdata, input logic exp_err, input string msg,
                        output logic [63:0] rdata);
   int   waits;
   int   exp_waits;
   logic stall_err;
   waits     = 0;
   stall_err = 1'b0;
   // errors and FIFO data reads each stall exactly one cycle
   exp_waits = (exp_err || (!wr && addr[7:2] == REG_FIFO_DATA)) ? 1 : 0;
   haddr_i  <= addr;
   hwrite_i <= wr;
   hsize_i  <= size;
   htrans_i <= HTRANS_NONSEQ;
   hsel_i   <= 1'b1;
   @(posedge hclk);
   drive_idle();
   hwdata_i <= wdata;
   @(posedge hclk);
   while (hreadyout_o !== 1'b1) begin
      waits++;
      stall_err = hresp_o;
      @(posedge hclk);
   end
   rdata = hrdata_o;
   check_waits(exp_waits, waits, msg);
   check_resp(exp_err, hresp_o, msg);
   if (exp_waits == 1 && waits >= 1) begin
      check_resp(exp_err, stall_err, {msg, " stall cycle"});
   end
endtask

task automatic ahb_write(input logic [31:0] addr, input hsize_e size, input logic [31:0] value,
                         input logic exp_err, input string msg);
   logic [63:0] wdata;
   logic [63:0] rdata;
   // word data goes only in its lane and the other lane carries junk
   if (size == HSIZE_WORD) begin
      wdata = addr[2] ? {value, ~value} : {~value, value};
   end else begin
      wdata = {2{value}};
   end
   ahb_xfer(addr, 1'b1, size, wdata, exp_err, msg, rdata);
endtask

task automatic ahb_read(input logic [31:0] addr, input logic exp_err,
                        output logic [31:0] value, input string msg);
   logic [63:0] rdata;
   ahb_xfer(addr, 1'b0, HSIZE_WORD, 64'h0, exp_err, msg, rdata);
   value = addr[2] ? rdata[63:32] : rdata[31:0];
   if (!exp_err) begin
      check_data(32'h0, addr[2] ? rdata[31:0] : rdata[63:32], {msg, " unused lane"});
   end
endtask

// zero-wait word transfers where the address of k overlaps the data of k-1
task automatic ahb_back_to_back(input logic wr, input int n);
   for (int k = 0; k <= n; k++) begin
      if (k < n) begin
         haddr_i  <= pipe_addr[k];
         hwrite_i <= wr;
         hsize_i  <= HSIZE_WORD;
         htrans_i <= (k == 0) ? HTRANS_NONSEQ : HTRANS_SEQ;
         hsel_i   <= 1'b1;
      end else begin
         drive_idle();
      end
      if (k > 0) begin
         hwdata_i <= pipe_addr[k-1][2] ? {pipe_data[k-1], 32'h0} : {32'h0, pipe_data[k-1]};
      end
      @(posedge hclk);
      check_bus_quiet("back-to-back transfer");
      if (k > 0 && !wr) begin
         pipe_data[k-1] = pipe_addr[k-1][2] ? hrdata_o[63:32] : hrdata_o[31:0];
      end
   end
endtask

// address phase that must not open a data phase
task automatic drive_no_xfer(input htrans_e trans, input logic sel, input logic [31:0] addr);
   haddr_i  <= addr;
   hwrite_i <= 1'b1;
   hsize_i  <= HSIZE_WORD;
   htrans_i <= trans;
   hsel_i   <= sel;
   @(posedge hclk);
   drive_idle();
   hwdata_i <= 64'hdead_beef_dead_beef;
   @(posedge hclk);
   check_bus_quiet("non-transfer");
endtask

task automatic check_stat(input string msg);
   logic [31:0] got;
   ahb_read(reg_addr(REG_FIFO_STAT), 1'b0, got, msg);
   check_addr_state(REG_FIFO_STAT, stat_expect(fifo_m.size()), got);
endtask

task automatic verify_all_regs(input string msg);
   logic [31:0] got;
   ahb_read(reg_addr(REG_ID), 1'b0, got, msg);
   check_addr_state(REG_ID, `REG_BLK_ID, got);
   ahb_read(reg_addr(REG_CTRL), 1'b0, got, msg);
   check_addr_state(REG_CTRL, {31'h0, lock_m}, got);
   check_stat(msg);
   for (int i = 0; i < `REG_NUM_SCRATCH; i++) begin
      ahb_read(reg_addr(scratch_sel(i)), 1'b0, got, msg);
      check_addr_state(scratch_sel(i), scratch_m[i], got);
   end
endtask

task automatic test_reset_state();
   logic [31:0] got;
   check_bus_quiet("idle after reset");
   ahb_read(reg_addr(REG_ID), 1'b0, got, "ID read after reset");
   check_addr_state(REG_ID, `REG_BLK_ID, got);
   check_stat("FIFO_STAT after reset");
endtask

task automatic test_scratch_rw();
   logic [31:0] val;
   for (int i = 0; i < `REG_NUM_SCRATCH; i++) begin
      val = $urandom;
      ahb_write(reg_addr(scratch_sel(i)), HSIZE_WORD, val, 1'b0, "scratch word write");
      scratch_m[i] = val;
   end
   val = $urandom;
   ahb_write(reg_addr(scratch_sel(0)), HSIZE_BYTE, val, 1'b0, "scratch byte write");
   scratch_m[0] = {24'h0, val[7:0]};
   val = $urandom;
   ahb_write(reg_addr(scratch_sel(3)), HSIZE_HALF, val, 1'b0, "scratch half write");
   scratch_m[3] = {16'h0, val[15:0]};
   verify_all_regs("scratch readback");
endtask

task automatic test_lock();
   logic [31:0] val;
   ahb_write(reg_addr(REG_CTRL), HSIZE_WORD, 32'h1, 1'b0, "lock set");
   lock_m = 1'b1;
   val = $urandom;
   ahb_write(reg_addr(scratch_sel(2)), HSIZE_WORD, val, 1'b1, "locked scratch write");
   ahb_write(reg_addr(scratch_sel(5)), HSIZE_BYTE, val, 1'b1, "locked scratch byte write");
   verify_all_regs("while locked");
   ahb_write(reg_addr(REG_CTRL), HSIZE_WORD, 32'h0, 1'b0, "lock clear");
   lock_m = 1'b0;
   ahb_write(reg_addr(scratch_sel(2)), HSIZE_WORD, val, 1'b0, "unlocked scratch write");
   scratch_m[2] = val;
   verify_all_regs("after unlock");
endtask

task automatic test_fifo();
   logic [31:0] val;
   logic [31:0] got;
   for (int i = 0; i < `REG_FIFO_DEPTH; i++) begin
      val = $urandom;
      ahb_write(reg_addr(REG_FIFO_DATA), HSIZE_WORD, val, 1'b0, "FIFO push");
      fifo_m.push_back(val);
      check_stat("FIFO_STAT after push");
   end
   ahb_write(reg_addr(REG_FIFO_DATA), HSIZE_WORD, $urandom, 1'b1, "FIFO push when full");
   check_stat("FIFO_STAT after overflow");
   for (int i = 0; i < `REG_FIFO_DEPTH; i++) begin
      ahb_read(reg_addr(REG_FIFO_DATA), 1'b0, got, "FIFO pop");
      check_data(fifo_m.pop_front(), got, "FIFO data order");
      check_stat("FIFO_STAT after pop");
   end
   ahb_read(reg_addr(REG_FIFO_DATA), 1'b1, got, "FIFO pop when empty");
   check_stat("FIFO_STAT after underflow");
endtask

task automatic test_illegal();
   logic [31:0] got;
   ahb_write(reg_addr(REG_ID), HSIZE_WORD, $urandom, 1'b1, "ID write");
   ahb_write(reg_addr(REG_FIFO_STAT), HSIZE_WORD, $urandom, 1'b1, "FIFO_STAT write");
   ahb_write(BASE_ADDR + 32'h20, HSIZE_WORD, $urandom, 1'b1, "unmapped write");
   ahb_write(BASE_ADDR + 32'h10, HSIZE_BYTE, $urandom, 1'b1, "unmapped byte write");
   ahb_read(BASE_ADDR + 32'h7c, 1'b1, got, "unmapped read");
   verify_all_regs("after illegal accesses");
endtask

task automatic test_no_xfer();
   drive_no_xfer(HTRANS_IDLE, 1'b1, reg_addr(scratch_sel(1)));
   drive_no_xfer(HTRANS_BUSY, 1'b1, reg_addr(scratch_sel(1)));
   drive_no_xfer(HTRANS_NONSEQ, 1'b0, reg_addr(REG_CTRL));
   verify_all_regs("after non-transfers");
   for (int k = 0; k < 4; k++) begin
      pipe_addr[k]     = reg_addr(scratch_sel(4 + k));
      pipe_data[k]     = $urandom;
      scratch_m[4 + k] = pipe_data[k];
   end
   ahb_back_to_back(1'b1, 4);
   ahb_back_to_back(1'b0, 4);
   for (int k = 0; k < 4; k++) begin
      check_addr_state(scratch_sel(4 + k), scratch_m[4 + k], pipe_data[k]);
   end
endtask

`endif

/* tb_ahb_reg_top.sv */
// testbench for the AHB register peripheral, directed tests over AHB-Lite
// compile with list.f, top module is tb_ahb_reg_top
`timescale 1ns/1ps
`default_nettype none
`include "ahb_cfg.svh"

module tb_ahb_reg_top;

   import ahb_bus_pkg::*;
   import reg_blk_pkg::*;

   localparam int          CLK_HALF   = 50;
   // tests take roughly 400 cycles
   localparam int          MAX_CYCLES = 2000;
   localparam logic [31:0] BASE_ADDR  = 32'h4000_0000;

   logic                       hclk;
   logic                       hreset_n;
   logic [`ADDR_WIDTH-1:0]     haddr_i;
   logic [`AHB_DATA_WIDTH-1:0] hwdata_i;
   logic                       hsel_i;
   logic                       hwrite_i;
   logic                       hready_i;
   htrans_e                    htrans_i;
   hsize_e                     hsize_i;
   logic                       hresp_o;
   logic                       hreadyout_o;
   logic [`AHB_DATA_WIDTH-1:0] hrdata_o;

   // reference model of the register block
   logic [31:0] scratch_m [`REG_NUM_SCRATCH];
   logic        lock_m;
   logic [31:0] fifo_m [$];

   // back-to-back sequence addresses and data
   logic [31:0] pipe_addr [4];
   logic [31:0] pipe_data [4];

   int errors = 0;
   int checks = 0;
   int cycles = 0;

   // single slave, so the bus ready is the slave's own
   assign hready_i = hreadyout_o;

   ahb_reg_top dut_i (
      .hclk        (hclk),
      .hreset_n    (hreset_n),
      .haddr_i     (haddr_i),
      .hwdata_i    (hwdata_i),
      .hsel_i      (hsel_i),
      .hwrite_i    (hwrite_i),
      .hready_i    (hready_i),
      .htrans_i    (htrans_i),
      .hsize_i     (hsize_i),
      .hresp_o     (hresp_o),
      .hreadyout_o (hreadyout_o),
      .hrdata_o    (hrdata_o)
   );

   `include "tb_ahb_reg_tasks.svh"

   initial begin
      hclk = 1'b0;
      forever #CLK_HALF hclk = ~hclk;
   end

   always @(posedge hclk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: tests still running after %0d cycles", MAX_CYCLES);
         $display("Finished with errors");
         $finish;
      end
   end

   initial begin
      void'($urandom(32'hee4c_07d2));
      hreset_n = 1'b0;
      haddr_i  = '0;
      hwdata_i = '0;
      hsel_i   = 1'b0;
      hwrite_i = 1'b0;
      htrans_i = HTRANS_IDLE;
      hsize_i  = HSIZE_WORD;
      lock_m   = 1'b0;
      repeat (5) @(posedge hclk);
      hreset_n <= 1'b1;
      @(posedge hclk);

      test_reset_state();
      test_scratch_rw();
      test_lock();
      test_fifo();
      test_illegal();
      test_no_xfer();

      $display("checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire
